/* list.f */
source/rename_pkg.sv
source/inst_pkg.sv
source/map_table.sv
source/free_list.sv
source/rename_rob.sv
source/rename_stage.sv
tests/rename_assert.sv
tests/rename_tb.sv

/* Bender.yml */
package:
  name: rename_stage

sources:
  - target: rtl
    files:
      - source/rename_pkg.sv
      - source/inst_pkg.sv
      - source/map_table.sv
      - source/free_list.sv
      - source/rename_rob.sv
      - source/rename_stage.sv
  - target: test
    files:
      - tests/rename_assert.sv
      - tests/rename_tb.sv

/* tests/rename_tb.sv */
// rename_tb: lfsr stimulus, reference model of map, free queue and rob, compare tasks, report
module rename_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rename_pkg::*;
  import inst_pkg::*;

  logic clock = 0;
  logic reset = 1;
  logic dispatch = 0;
  inst_form_t inst_form = form_reg;
  inst_word_t inst_word = '0;
  logic cdb_valid = 0;
  phys_tag_t cdb_tag = '0;
  logic rollback = 0;
  rob_idx_t rollback_idx = '0;
  logic stall, retire;
  map_entry_t tag_a, tag_b;
  phys_tag_t tag_old, tag_new, retire_tag;
  rob_idx_t rob_idx;

  // reference model state
  phys_tag_t m_tag [32];
  logic m_rdy [32];
  phys_tag_t ck_tag [8][32];  // checkpoint maps, ready implied
  phys_tag_t fq [64];
  int f_rd, f_wr;             // 7-bit pointers kept mod 128
  int f_ck [8];
  logic r_valid [8];
  logic r_done [8];
  phys_tag_t r_new [8];
  phys_tag_t r_old [8];
  int r_head, r_tail, r_count;

  logic [15:0] lfsr = 16'd28;
  logic hold = 0;             // last cycle stalled, keep instruction
  string test_name = "";      // test in progress, shown on error lines
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int err_mark = 0;
  int waited;

  rename_stage rename_stage_inst (.*);

  always #2 clock = ~clock;

  // fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [15:0] rand_bits(int n);
    logic [15:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[14:0], fb};
    end
    return v;
  endfunction

  task automatic check_tag(string name, phys_tag_t exp, phys_tag_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, name, exp, act);
    end
  endtask

  task automatic check_entry(string name, map_entry_t exp, map_entry_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s: expected tag %0d ready %b, actual tag %0d ready %b",
               test_name, name, exp.tag, exp.ready, act.tag, act.ready);
    end
  endtask

  task automatic check_idx(string name, rob_idx_t exp, rob_idx_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s: expected %b, actual %b", test_name, name, exp, act);
    end
  endtask

  task automatic end_test(string name);
    tests++;
    $display("%s: done, %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // one cycle: drive, compare against model, advance model, wait for the edge
  task automatic step(logic want_disp, logic want_cdb, logic want_rb);
    arch_reg_t dest, sa, sb;
    phys_tag_t nmap [32];
    logic nrdy [32];
    logic acc, ret;
    phys_tag_t rtag, old_t, new_t;
    int span, hd;
    #1;
    if (!hold) begin
      dispatch = want_disp;
      inst_form = inst_form_t'(rand_bits(1));
      inst_word = rand_bits(16);
    end
    cdb_valid = want_cdb && r_count > 0;
    if (cdb_valid) cdb_tag = r_new[(r_head + rand_bits(3) % r_count) % 8];
    rollback = want_rb && r_count > 0;
    if (rollback) rollback_idx = rob_idx_t'((r_head + rand_bits(3) % r_count) % 8);
    #2;
    dest = (inst_form == form_imm) ? inst_word.imm.dest : inst_word.rf.dest;
    sa = (inst_form == form_imm) ? inst_word.imm.src_a : inst_word.rf.src_a;
    sb = (inst_form == form_imm) ? inst_word.imm.src_a : inst_word.rf.src_b;  // imm reuses src_a
    old_t = m_tag[dest];
    new_t = fq[f_rd % 64];
    ret = r_valid[r_head] && r_done[r_head];
    rtag = r_old[r_head];
    acc = dispatch && r_count < 8 && f_rd != f_wr && !rollback;
    check_entry("tag_a", '{tag: m_tag[sa], ready: m_rdy[sa]}, tag_a);
    check_entry("tag_b", '{tag: m_tag[sb], ready: m_rdy[sb]}, tag_b);
    check_tag("tag_old", old_t, tag_old);
    check_tag("tag_new", new_t, tag_new);
    check_idx("rob_idx", rob_idx_t'(r_tail), rob_idx);  // slot this dispatch would take
    check_bit("stall", r_count == 8 || f_rd == f_wr, stall);
    check_bit("retire", ret, retire);
    if (ret) check_tag("retire_tag", rtag, retire_tag);
    hold = dispatch && stall;
    // map: rollback restores, cdb sets ready, dispatch writes dest
    for (int i = 0; i < 32; i++) begin
      nmap[i] = rollback ? ck_tag[rollback_idx][i] : m_tag[i];
      nrdy[i] = rollback ? 1'b1 : m_rdy[i];
      if (cdb_valid && nmap[i] == cdb_tag) nrdy[i] = 1'b1;
    end
    if (acc) begin
      nmap[dest] = new_t;
      nrdy[dest] = 1'b0;
      for (int i = 0; i < 32; i++) ck_tag[r_tail][i] = nmap[i];
    end
    m_tag = nmap;
    m_rdy = nrdy;
    // free queue
    if (rollback) begin
      f_rd = (f_ck[rollback_idx] + 1) % 128;
    end else if (acc) begin
      f_ck[r_tail] = f_rd;
      f_rd = (f_rd + 1) % 128;
    end
    if (ret) begin
      fq[f_wr % 64] = rtag;
      f_wr = (f_wr + 1) % 128;
    end
    // rob
    hd = r_head;
    span = (rollback_idx - hd) & 7;
    for (int i = 0; i < 8; i++) begin
      if (cdb_valid && r_valid[i] && r_new[i] == cdb_tag) r_done[i] = 1'b1;
    end
    if (ret) begin
      r_valid[hd] = 1'b0;
      r_head = (hd + 1) % 8;
    end
    if (rollback) begin
      for (int i = 0; i < 8; i++) begin
        if (((i - hd) & 7) > span) r_valid[i] = 1'b0;  // squashed
      end
      r_tail = (rollback_idx + 1) % 8;
      r_count = span + 1 - ret;
    end else if (acc) begin
      r_valid[r_tail] = 1'b1;
      r_done[r_tail] = 1'b0;
      r_new[r_tail] = new_t;
      r_old[r_tail] = old_t;
      r_tail = (r_tail + 1) % 8;
      r_count = r_count + 1 - ret;
    end else begin
      r_count = r_count - ret;
    end
    @(posedge clock);
  endtask

  // drain the rob through cdb broadcasts, bounded
  task automatic drain(string name);
    waited = 0;
    while (r_count > 0 && waited < 100) begin
      step(0, 1, 0);
      waited++;
    end
    if (r_count > 0) begin
      errors++;
      $display("%s: ROB did not drain within 100 cycles", name);
    end
  endtask

  initial begin
    for (int r = 0; r < 32; r++) begin
      m_tag[r] = phys_tag_t'(r);  // identity map after reset
      m_rdy[r] = 1'b1;
    end
    for (int i = 0; i < 64; i++) fq[i] = phys_tag_t'(i + 32);
    f_rd = 0;
    f_wr = 32;
    for (int i = 0; i < 8; i++) begin
      r_valid[i] = 0;
      r_done[i] = 0;
    end
    r_head = 0;
    r_tail = 0;
    r_count = 0;
    repeat (3) @(posedge clock);
    #1 reset = 0;
    @(posedge clock);

    test_name = "reset_map";
    for (int r = 0; r < 32; r++) begin
      #1 inst_form = form_reg;
      inst_word.rf.src_a = arch_reg_t'(r);
      #2 check_entry("reset_map", '{tag: phys_tag_t'(r), ready: 1'b1}, tag_a);
      @(posedge clock);
    end
    for (int i = 0; i < 4; i++) begin
      #1 dispatch = 0;  // idle cycle, head of queue visible
      #2 check_tag("first_tags", phys_tag_t'(32 + i), tag_new);  // queue order
      @(posedge clock);
      step(1, 0, 0);
    end
    end_test("reset_map");

    test_name = "random_dispatch";
    repeat (200) step(rand_bits(2) != 0, rand_bits(1), 0);
    end_test("random_dispatch");

    test_name = "cdb_retire";
    drain("cdb_retire");
    end_test("cdb_retire");

    test_name = "rollback";
    repeat (150) step(rand_bits(1), rand_bits(1), rand_bits(3) == 0);
    drain("rollback");
    end_test("rollback");

    test_name = "stall";
    waited = 0;
    while (r_count < 8 && waited < 50) begin
      step(1, 0, 0);
      waited++;
    end
    if (r_count < 8) begin
      errors++;
      $display("stall: ROB never filled within 50 cycles");
    end
    repeat (6) step(1, 0, 0);
    drain("stall");
    end_test("stall");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #100000;
    $display("simulation ran past its time limit");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* tests/rename_assert.sv */
// rename_assert: reset, stall hold and tag uniqueness properties bound into rename_stage
module rename_assert (
  input logic                   clock,
  input logic                   reset,
  input logic                   dispatch,
  input logic                   accept,       // internal write enable
  input inst_pkg::inst_form_t   inst_form,
  input inst_pkg::inst_word_t   inst_word,
  input logic                   cdb_valid,
  input logic                   rollback,
  input logic                   stall,
  input rename_pkg::map_entry_t tag_a,
  input rename_pkg::map_entry_t tag_b,
  input rename_pkg::phys_tag_t  tag_old,
  input rename_pkg::phys_tag_t  tag_new,
  input logic                   retire
);
  timeunit 1ns;
  timeprecision 100ps;

  // rob is cleared by the reset cycle
  retire_low_in_reset: assert property (@(posedge clock) reset |=> !retire)
    else $error("retire rose during reset");

  // held instruction, nothing else moving the map
  lookup_stable_on_stall: assert property (@(posedge clock) disable iff (reset)
    stall && dispatch && !cdb_valid && !rollback ##1
    dispatch && $stable(inst_word) && $stable(inst_form)
    |-> $stable(tag_a) && $stable(tag_b) && $stable(tag_old) && $stable(tag_new))
    else $error("lookup outputs moved while stalled");

  new_tag_unique: assert property (@(posedge clock) disable iff (reset)
    accept ##1 accept |-> tag_new != $past(tag_new))
    else $error("same tag_new handed out twice in a row");

endmodule

bind rename_stage rename_assert rename_assert_inst (.*);

/* source/rename_stage.sv */
// rename_stage: top level joining map table, free list and rob
module rename_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatch,
  input  inst_pkg::inst_form_t   inst_form,
  input  inst_pkg::inst_word_t   inst_word,
  input  logic                   cdb_valid,
  input  rename_pkg::phys_tag_t  cdb_tag,
  input  logic                   rollback,
  input  rename_pkg::rob_idx_t   rollback_idx,
  output logic                   stall,
  output rename_pkg::map_entry_t tag_a,
  output rename_pkg::map_entry_t tag_b,
  output rename_pkg::phys_tag_t  tag_old,
  output rename_pkg::phys_tag_t  tag_new,
  output rename_pkg::rob_idx_t   rob_idx,     // also the checkpoint slot
  output logic                   retire,
  output rename_pkg::phys_tag_t  retire_tag
);

  logic accept;      // write enable for map and free list
  logic free_empty;

  map_table map_table_inst (
    .clock        (clock),
    .reset        (reset),
    .accept       (accept),
    .inst_form    (inst_form),
    .inst_word    (inst_word),
    .tag_new      (tag_new),
    .rob_tail     (rob_idx),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .rollback     (rollback),
    .rollback_idx (rollback_idx),
    .tag_a        (tag_a),
    .tag_b        (tag_b),
    .tag_old      (tag_old)
  );

  free_list free_list_inst (
    .clock        (clock),
    .reset        (reset),
    .accept       (accept),
    .rob_tail     (rob_idx),
    .retire       (retire),       // retired old tags come back here
    .retire_tag   (retire_tag),
    .rollback     (rollback),
    .rollback_idx (rollback_idx),
    .head_tag     (tag_new),
    .free_empty   (free_empty)
  );

  rename_rob rename_rob_inst (
    .clock        (clock),
    .reset        (reset),
    .dispatch     (dispatch),
    .free_empty   (free_empty),
    .tag_new      (tag_new),
    .tag_old      (tag_old),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .rollback     (rollback),
    .rollback_idx (rollback_idx),
    .accept       (accept),
    .stall        (stall),
    .rob_tail     (rob_idx),
    .retire       (retire),
    .retire_tag   (retire_tag)
  );

endmodule

/* source/rename_rob.sv */
// rename_rob: in-order tag tracking, cdb completion, retirement, rollback, dispatch accept
module rename_rob (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch,
  input  logic                  free_empty,
  input  rename_pkg::phys_tag_t tag_new,
  input  rename_pkg::phys_tag_t tag_old,
  input  logic                  cdb_valid,
  input  rename_pkg::phys_tag_t cdb_tag,
  input  logic                  rollback,
  input  rename_pkg::rob_idx_t  rollback_idx,
  output logic                  accept,
  output logic                  stall,
  output rename_pkg::rob_idx_t  rob_tail,
  output logic                  retire,
  output rename_pkg::phys_tag_t retire_tag
);
  import rename_pkg::*;

  logic [rob_depth-1:0] valid_q;
  logic [rob_depth-1:0] done_q;      // result seen on cdb
  phys_tag_t            new_q [rob_depth];
  phys_tag_t            old_q [rob_depth];
  rob_idx_t             head_q;
  rob_idx_t             tail_q;
  logic [rob_idx_bits:0] count_q;    // 0..8
  rob_idx_t             span;        // distance head to rollback target
  logic [rob_idx_bits:0] kept;       // entries left after rollback
  logic                 full;

  assign full     = (count_q == rob_depth);
  assign stall    = full | free_empty;
  assign accept   = dispatch & ~full & ~free_empty & ~rollback;  // rollback wins
  assign rob_tail = tail_q;

  // head leaves once done, one per cycle
  assign retire     = valid_q[head_q] & done_q[head_q];
  assign retire_tag = old_q[head_q];

  assign span = rob_idx_t'(rollback_idx - head_q);
  assign kept = {1'b0, span} + 1'b1;  // target itself survives

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      done_q  <= '0;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      for (int i = 0; i < rob_depth; i++) begin
        if (cdb_valid && valid_q[i] && new_q[i] == cdb_tag) begin
          done_q[i] <= 1'b1;
        end
      end
      if (retire) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      if (rollback) begin
        for (int i = 0; i < rob_depth; i++) begin
          if (rob_idx_t'(rob_idx_t'(i) - head_q) > span) begin
            valid_q[i] <= 1'b0;  // younger than the branch
          end
        end
        tail_q  <= rollback_idx + 1'b1;
        count_q <= kept - retire;
      end else if (accept) begin
        valid_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= 1'b0;
        tail_q          <= tail_q + 1'b1;
        count_q         <= count_q + 1'b1 - retire;
      end else begin
        count_q <= count_q - retire;
      end
    end
  end

  // tag payload
  always_ff @(posedge clock) begin
    if (accept) begin
      new_q[tail_q] <= tag_new;
      old_q[tail_q] <= tag_old;
    end
  end

endmodule

/* source/free_list.sv */
// free_list: circular queue of free physical tags, read pointer checkpoints per rob slot
module free_list (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  accept,      // pop head
  input  rename_pkg::rob_idx_t  rob_tail,    // checkpoint slot
  input  logic                  retire,      // push retire_tag
  input  rename_pkg::phys_tag_t retire_tag,
  input  logic                  rollback,
  input  rename_pkg::rob_idx_t  rollback_idx,
  output rename_pkg::phys_tag_t head_tag,
  output logic                  free_empty
);
  import rename_pkg::*;

  // one extra bit tells full from empty
  logic [tag_bits:0] rd_ptr;
  logic [tag_bits:0] wr_ptr;
  logic [tag_bits:0] ckpt_q [rob_depth];  // rd_ptr before each dispatch

  phys_tag_t slots [num_phys_regs];

  assign head_tag   = slots[rd_ptr[tag_bits-1:0]];
  assign free_empty = (rd_ptr == wr_ptr);

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= (tag_bits + 1)'(num_phys_regs - num_arch_regs);  // 32 tags queued
    end else begin
      if (rollback) begin
        // step past the branch's own tag, squashed ones become free again
        rd_ptr <= ckpt_q[rollback_idx] + 1'b1;
      end else if (accept) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (retire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // queue storage
  // reset loads 32..63 into the first half, the rest is past wr_ptr
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_phys_regs; i++) begin
        slots[i] <= phys_tag_t'(i + num_arch_regs);  // wraps mod 64
      end
    end else if (retire) begin
      slots[wr_ptr[tag_bits-1:0]] <= retire_tag;  // freed tag at the back
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      ckpt_q[rob_tail] <= rd_ptr;  // pointer before the pop
    end
  end

endmodule

/* source/map_table.sv */
// map_table: arch-to-phys map with ready bits, operand lookup, rob-indexed checkpoints
module map_table (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   accept,        // dispatch taken this cycle
  input  inst_pkg::inst_form_t   inst_form,
  input  inst_pkg::inst_word_t   inst_word,
  input  rename_pkg::phys_tag_t  tag_new,       // from free list head
  input  rename_pkg::rob_idx_t   rob_tail,      // checkpoint slot
  input  logic                   cdb_valid,
  input  rename_pkg::phys_tag_t  cdb_tag,
  input  logic                   rollback,
  input  rename_pkg::rob_idx_t   rollback_idx,
  output rename_pkg::map_entry_t tag_a,
  output rename_pkg::map_entry_t tag_b,
  output rename_pkg::phys_tag_t  tag_old
);
  import rename_pkg::*;
  import inst_pkg::*;

  map_entry_t map_q    [num_arch_regs];              // current map
  map_entry_t map_next [num_arch_regs];
  map_entry_t snap     [num_arch_regs];              // next map, all ready
  map_entry_t ckpt_q   [rob_depth][num_arch_regs];   // one copy per rob slot

  arch_reg_t dest;
  arch_reg_t src_a;
  arch_reg_t src_b;

  // operand decode
  always_comb begin
    if (inst_form == form_imm) begin
      dest  = inst_word.imm.dest;
      src_a = inst_word.imm.src_a;
      src_b = inst_word.imm.src_a;  // no second source, mirror src_a
    end else begin
      dest  = inst_word.rf.dest;
      src_a = inst_word.rf.src_a;
      src_b = inst_word.rf.src_b;
    end
  end

  // lookups read the map before this cycle's write
  assign tag_a   = map_q[src_a];
  assign tag_b   = map_q[src_b];
  assign tag_old = map_q[dest].tag;  // goes to rob, freed at retire

  // next map: rollback, then cdb, then dispatch
  always_comb begin
    map_next = map_q;
    if (rollback) begin
      map_next = ckpt_q[rollback_idx];
    end
    // cdb also applies on top of a restored map
    if (cdb_valid) begin
      for (int i = 0; i < num_arch_regs; i++) begin
        if (map_next[i].tag == cdb_tag) begin
          map_next[i].ready = 1'b1;
        end
      end
    end
    if (accept) begin
      map_next[dest] = '{tag: tag_new, ready: 1'b0};  // result pending
    end
  end

  // checkpoint image with every ready bit forced on
  always_comb begin
    for (int i = 0; i < num_arch_regs; i++) begin
      snap[i] = '{tag: map_next[i].tag, ready: 1'b1};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < num_arch_regs; r++) begin
        map_q[r] <= '{tag: phys_tag_t'(r), ready: 1'b1};  // identity map
      end
    end else begin
      map_q <= map_next;
    end
  end

  // snapshot taken under the dispatching instruction's rob slot
  always_ff @(posedge clock) begin
    if (accept) begin
      ckpt_q[rob_tail] <= snap;
    end
  end

endmodule

/* source/inst_pkg.sv */
// inst_pkg: dispatched instruction word, register and immediate field layouts, form select
package inst_pkg;

  localparam int imm_bits = 6;  // immediate field in imm form

  // how the word below is read
  typedef enum logic {
    form_reg = 1'b0,
    form_imm = 1'b1
  } inst_form_t;

  // register form, three renamed operands
  typedef struct packed {
    rename_pkg::arch_reg_t dest;
    rename_pkg::arch_reg_t src_a;
    rename_pkg::arch_reg_t src_b;
    logic                  spare;  // pads to 16
  } reg_fields_t;

  // immediate form, single source
  typedef struct packed {
    rename_pkg::arch_reg_t dest;
    rename_pkg::arch_reg_t src_a;
    logic [imm_bits-1:0]   imm;   // not renamed, passes on untouched
  } imm_fields_t;

  // same 16 bits, two readings
  typedef union packed {
    reg_fields_t rf;
    imm_fields_t imm;
  } inst_word_t;

endpackage

/* source/rename_pkg.sv */
// rename_pkg: register counts, rob size, tag and index types, map entry struct
package rename_pkg;

  // machine sizes
  localparam int num_arch_regs = 32;
  localparam int num_phys_regs = 64;
  localparam int rob_depth     = 8;

  // field widths derived from the sizes
  localparam int arch_bits    = $clog2(num_arch_regs);  // 5
  localparam int tag_bits     = $clog2(num_phys_regs);  // 6
  localparam int rob_idx_bits = $clog2(rob_depth);      // 3

  typedef logic [arch_bits-1:0]    arch_reg_t;  // architectural register number
  typedef logic [tag_bits-1:0]     phys_tag_t;  // physical register tag
  typedef logic [rob_idx_bits-1:0] rob_idx_t;   // rob slot

  // one map table slot
  typedef struct packed {
    phys_tag_t tag;
    logic      ready;  // value already on the cdb
  } map_entry_t;

endpackage
